/* Makefile */
# Verilator build and run of the text LCD controller testbench

VERILATOR  ?= verilator
TOP        ?= txtlcd_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
src/lcd_pkg.sv
src/bus_pkg.sv
src/serial_shifter.sv
src/text_ram.sv
src/ram_arbiter.sv
src/apb_text_regs.sv
src/txtlcd_refresh.sv
src/txtlcd_top.sv
verification/txtlcd_tb.sv

/* src/apb_text_regs.sv */
/*
 * apb register block
 * control, status and a character window onto the text ram
 */
`timescale 1ns/1ps
`default_nettype none

module apb_text_regs #(
	parameter int LCD_SIZE = 80
) (
	input  logic              clk27,
	input  logic              arst_n,
	input  bus_pkg::apb_req_t apb_req,
	input  bus_pkg::ram_rsp_t ram_rsp,
	input  logic              busy,
	input  logic              init_done,
	output bus_pkg::apb_rsp_t apb_rsp,
	output bus_pkg::ram_req_t ram_req,
	output logic              update_req
);

	// low byte, high byte, waiting for high read data
	typedef enum logic [1:0] {S_LO, S_HI, S_RD} win_st_e;

	win_st_e    st;
	logic       access;
	logic       is_ctrl;
	logic       is_stat;
	logic       is_win;
	logic [5:0] word_off;
	logic [6:0] win_idx;
	logic       done;
	logic [7:0] lo_q;

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	assign access   = apb_req.psel & apb_req.penable;
	assign word_off = apb_req.paddr - 6'h10;
	assign win_idx  = {word_off, 1'b0};
	assign is_ctrl  = (apb_req.paddr == 6'h00);
	assign is_stat  = (apb_req.paddr == 6'h01);
	// both bytes of the word must fit in the screen
	assign is_win   = (apb_req.paddr >= 6'h10) &&
		(({1'b0, win_idx} + 8'd1) < 8'(LCD_SIZE));

	// write ends on the high byte grant, read on its data
	assign done = access && is_win &&
		((st == S_HI && ram_rsp.gnt && apb_req.pwrite) ||
		 (st == S_RD && ram_rsp.rvalid));

	// ------------------------------------------------------------
	// window byte sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			st <= S_LO;
		end else if (access && is_win) begin
			case (st)
				S_LO: if (ram_rsp.gnt)
					st <= S_HI;
				S_HI: if (ram_rsp.gnt)
					st <= apb_req.pwrite ? S_LO : S_RD;
				S_RD: if (ram_rsp.rvalid)
					st <= S_LO;
				default: st <= S_LO;
			endcase
		end
	end

	// low byte data shows up while the high byte is requested
	always_ff @(posedge clk27) begin
		if (st == S_HI && ram_rsp.rvalid)
			lo_q <= ram_rsp.rdata;
	end

	always_comb begin
		ram_req.req   = access && is_win && (st != S_RD);
		ram_req.we    = apb_req.pwrite;
		ram_req.addr  = (st == S_LO) ? win_idx : win_idx + 7'd1;
		ram_req.wdata = (st == S_LO) ? apb_req.pwdata[7:0] : apb_req.pwdata[15:8];
	end

	// ------------------------------------------------------------
	// response
	// ------------------------------------------------------------
	always_comb begin
		apb_rsp.pready  = access && (!is_win || done);
		apb_rsp.pslverr = access && !(is_ctrl || is_stat || is_win);
		apb_rsp.prdata  = '0;
		if (is_stat)
			apb_rsp.prdata[1:0] = {init_done, busy};
		else if (is_win && st == S_RD)
			apb_rsp.prdata[15:0] = {ram_rsp.rdata, lo_q};
	end

	// ctrl bit 0 is a one-cycle strobe
	assign update_req = access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0];

endmodule

`default_nettype wire

/* src/bus_pkg.sv */
/*
 * bus definitions
 * apb slave port and text ram port request/response structs
 */
`default_nettype none

package bus_pkg;

	// apb request, paddr is a word address
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [5:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apb_rsp_t;

	// text ram request, held until gnt
	typedef struct packed {
		logic       req;
		logic       we;
		logic [6:0] addr;
		logic [7:0] wdata;
	} ram_req_t;

	// rvalid comes one cycle after gnt of a read
	typedef struct packed {
		logic       gnt;
		logic       rvalid;
		logic [7:0] rdata;
	} ram_rsp_t;

endpackage

`default_nettype wire

/* src/lcd_pkg.sv */
/*
 * text lcd protocol definitions
 * serial frame layout, init command table and row addresses
 */
`default_nettype none

package lcd_pkg;

	// panel geometry
	localparam int LCD_COLS = 20;
	localparam int LCD_ROWS = 4;

	// start byte, sent low bit first: sync ones, r/w, rs, zero
	typedef struct packed {
		logic       zero;
		logic       rs;
		logic       rw;
		logic [4:0] sync;
	} start_byte_t;

	// nibble byte, payload in the low four bits
	typedef struct packed {
		logic [3:0] pad;
		logic [3:0] nib;
	} nibble_byte_t;

	// byte 0 lives in the low bits and goes out first
	typedef struct packed {
		nibble_byte_t hi;
		nibble_byte_t lo;
		start_byte_t  start;
	} frame_fields_t;

	typedef union packed {
		logic [2:0][7:0] raw;
		frame_fields_t   fld;
	} lcd_frame_u;

	// function set (four lines), display on, clear, entry mode increment
	localparam logic [7:0] init_cmds [4] = '{8'h38, 8'h0c, 8'h01, 8'h06};

	// ddram base address of each row
	localparam logic [7:0] row_base [4] = '{8'h00, 8'h20, 8'h40, 8'h60};

endpackage

`default_nettype wire

/* src/ram_arbiter.sv */
/*
 * text ram arbiter
 * round-robin between the apb block and the refresh engine
 */
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter (
	input  logic              clk27,
	input  logic              arst_n,
	input  bus_pkg::ram_req_t host_req,
	input  bus_pkg::ram_req_t lcd_req,
	input  logic [7:0]        rdata,
	output bus_pkg::ram_rsp_t host_rsp,
	output bus_pkg::ram_rsp_t lcd_rsp,
	output bus_pkg::ram_req_t ram_req
);

	logic last_lcd;
	logic pick_lcd;
	logic pick_host;
	logic host_rv;
	logic lcd_rv;

	// lcd wins when alone or when the host was served last
	assign pick_lcd  = lcd_req.req && (!host_req.req || !last_lcd);
	assign pick_host = host_req.req && !pick_lcd;

	always_comb begin
		ram_req     = pick_lcd ? lcd_req : host_req;
		ram_req.req = pick_lcd | pick_host;
	end

	// remember the winner so read data goes back to it
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			last_lcd <= 1'b0;
			host_rv  <= 1'b0;
			lcd_rv   <= 1'b0;
		end else begin
			if (pick_lcd)
				last_lcd <= 1'b1;
			else if (pick_host)
				last_lcd <= 1'b0;
			host_rv <= pick_host && !host_req.we;
			lcd_rv  <= pick_lcd && !lcd_req.we;
		end
	end

	always_comb begin
		host_rsp.gnt    = pick_host;
		host_rsp.rvalid = host_rv;
		host_rsp.rdata  = rdata;
		lcd_rsp.gnt     = pick_lcd;
		lcd_rsp.rvalid  = lcd_rv;
		lcd_rsp.rdata   = rdata;
	end

endmodule

`default_nettype wire

/* src/serial_shifter.sv */
/*
 * lcd serial shifter
 * derives the serial clock and sends 24-bit frames, low bit first
 */
`timescale 1ns/1ps
`default_nettype none

module serial_shifter #(
	parameter int MAIN_CLK_HZ   = 27_000_000,
	parameter int SERIAL_CLK_HZ = 1_000_000
) (
	input  logic                clk27,
	input  logic                arst_n,
	input  lcd_pkg::lcd_frame_u frame,
	input  logic                frame_valid,
	output logic                frame_ready,
	output logic                lcd_scl,
	output logic                lcd_sda
);

	localparam int DIV  = MAIN_CLK_HZ / SERIAL_CLK_HZ;
	localparam int HALF = (DIV / 2 > 0) ? DIV / 2 : 1;
	localparam int CW   = $clog2(DIV + 1);

	typedef enum logic [1:0] {S_IDLE, S_LOW, S_HIGH, S_GAP} state_e;

	state_e        state;
	logic [CW-1:0] cnt;
	logic [4:0]    bit_cnt;
	logic [23:0]   shreg;
	logic          scl_q;
	logic          sda_q;
	logic          half_done;
	logic          load;
	logic          shift;

	assign half_done = (cnt == CW'(HALF - 1));
	assign load      = (state == S_IDLE) && frame_valid;
	// next bit goes out on the falling edge after the high half
	assign shift     = (state == S_HIGH) && half_done && (bit_cnt != 5'd23);

	// ------------------------------------------------------------
	// clock phases and bit count
	// ------------------------------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			state   <= S_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			scl_q   <= 1'b1;
			sda_q   <= 1'b1;
		end else begin
			case (state)
				S_IDLE: if (load) begin
					// falling edge puts bit 0 on the line
					scl_q   <= 1'b0;
					sda_q   <= frame.raw[0][0];
					cnt     <= '0;
					bit_cnt <= '0;
					state   <= S_LOW;
				end
				S_LOW: if (half_done) begin
					scl_q <= 1'b1;
					cnt   <= '0;
					state <= S_HIGH;
				end else begin
					cnt <= cnt + 1'b1;
				end
				S_HIGH: if (half_done) begin
					cnt <= '0;
					if (bit_cnt == 5'd23) begin
						// scl stays high through the gap
						state <= S_GAP;
					end else begin
						scl_q   <= 1'b0;
						sda_q   <= shreg[1];
						bit_cnt <= bit_cnt + 1'b1;
						state   <= S_LOW;
					end
				end else begin
					cnt <= cnt + 1'b1;
				end
				// one idle serial clock between frames
				S_GAP: if (cnt == CW'(DIV - 1)) begin
					cnt   <= '0;
					state <= S_IDLE;
				end else begin
					cnt <= cnt + 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// frame bits, byte 0 first
	always_ff @(posedge clk27) begin
		if (load)
			shreg <= frame.raw;
		else if (shift)
			shreg <= {1'b0, shreg[23:1]};
	end

	assign frame_ready = (state == S_IDLE);
	assign lcd_scl     = scl_q;
	assign lcd_sda     = sda_q;

endmodule

`default_nettype wire

/* src/text_ram.sv */
/*
 * text ram
 * one byte per screen cell, synchronous write and read
 */
`timescale 1ns/1ps
`default_nettype none

module text_ram #(
	parameter int LCD_SIZE = 80
) (
	input  logic              clk27,
	input  bus_pkg::ram_req_t req,
	output logic [7:0]        rdata
);

	// character cells in row-major order
	logic [7:0] mem [LCD_SIZE];

	always_ff @(posedge clk27) begin
		if (req.req) begin
			if (req.we)
				mem[req.addr] <= req.wdata;
			// read-before-write on the same address
			rdata <= mem[req.addr];
		end
	end

endmodule

`default_nettype wire

/* src/txtlcd_refresh.sv */
/*
 * lcd refresh engine
 * reset pulse, init commands, then full-screen updates from text ram
 */
`timescale 1ns/1ps
`default_nettype none

module txtlcd_refresh #(
	parameter int LCD_SIZE   = 80,
	parameter int RST_CYCLES = 27_000
) (
	input  logic                clk27,
	input  logic                arst_n,
	input  logic                update_req,
	input  bus_pkg::ram_rsp_t   ram_rsp,
	input  logic                frame_ready,
	output bus_pkg::ram_req_t   ram_req,
	output lcd_pkg::lcd_frame_u frame,
	output logic                frame_valid,
	output logic                lcd_rst,
	output logic                busy,
	output logic                init_done
);

	localparam int RW = $clog2(RST_CYCLES + 1);

	typedef enum logic [2:0] {S_RST, S_WAIT, S_INIT, S_IDLE, S_ADDR, S_DATA} state_e;

	state_e        state;
	logic [RW-1:0] rst_cnt;
	logic          cnt_done;
	logic [1:0]    cmd_idx;
	logic [1:0]    row;
	logic [4:0]    col;
	logic [6:0]    fetch_idx;
	logic          buf_full;
	logic          rd_pend;
	logic          upd_pend;
	logic          init_done_q;
	logic [7:0]    buf_q;
	logic          accept;
	logic          fetch;

	// start byte with sync ones, write only
	function automatic lcd_pkg::lcd_frame_u make_frame(input logic rs, input logic [7:0] b);
		lcd_pkg::lcd_frame_u fr;
		fr.fld.start.sync = 5'b11111;
		fr.fld.start.rw   = 1'b0;
		fr.fld.start.rs   = rs;
		fr.fld.start.zero = 1'b0;
		fr.fld.lo.pad     = 4'h0;
		fr.fld.lo.nib     = b[3:0];
		fr.fld.hi.pad     = 4'h0;
		fr.fld.hi.nib     = b[7:4];
		return fr;
	endfunction

	assign cnt_done = (rst_cnt == RW'(RST_CYCLES - 1));
	assign accept   = frame_valid & frame_ready;
	// one-byte prefetch runs ahead of the shifter during a refresh
	assign fetch    = (state == S_ADDR || state == S_DATA) && !buf_full && !rd_pend &&
		({1'b0, fetch_idx} < 8'(LCD_SIZE));

	// ------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			state       <= S_RST;
			rst_cnt     <= '0;
			cmd_idx     <= '0;
			row         <= '0;
			col         <= '0;
			fetch_idx   <= '0;
			buf_full    <= 1'b0;
			rd_pend     <= 1'b0;
			upd_pend    <= 1'b0;
			init_done_q <= 1'b0;
		end else begin
			// character prefetch
			if (fetch && ram_rsp.gnt) begin
				rd_pend   <= 1'b1;
				fetch_idx <= fetch_idx + 1'b1;
			end
			if (ram_rsp.rvalid) begin
				rd_pend  <= 1'b0;
				buf_full <= 1'b1;
			end
			if (accept && state == S_DATA)
				buf_full <= 1'b0;

			case (state)
				// lcd reset pulse, then boot wait of the same length
				S_RST, S_WAIT: if (cnt_done) begin
					rst_cnt <= '0;
					state   <= (state == S_RST) ? S_WAIT : S_INIT;
				end else begin
					rst_cnt <= rst_cnt + 1'b1;
				end
				S_INIT: if (accept) begin
					cmd_idx <= cmd_idx + 1'b1;
					if (cmd_idx == 2'd3) begin
						init_done_q <= 1'b1;
						state       <= S_IDLE;
					end
				end
				S_IDLE: if (upd_pend) begin
					upd_pend  <= 1'b0;
					row       <= '0;
					col       <= '0;
					fetch_idx <= '0;
					state     <= S_ADDR;
				end
				S_ADDR: if (accept)
					state <= S_DATA;
				S_DATA: if (accept) begin
					if (col == 5'(lcd_pkg::LCD_COLS - 1)) begin
						col <= '0;
						if (row == 2'(lcd_pkg::LCD_ROWS - 1)) begin
							state <= S_IDLE;
						end else begin
							row   <= row + 1'b1;
							state <= S_ADDR;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				default: state <= S_RST;
			endcase

			// request while busy is kept for one more pass
			if (update_req)
				upd_pend <= 1'b1;
		end
	end

	always_ff @(posedge clk27) begin
		if (ram_rsp.rvalid)
			buf_q <= ram_rsp.rdata;
	end

	// ------------------------------------------------------------
	// frame and ram request
	// ------------------------------------------------------------
	always_comb begin
		case (state)
			S_INIT:  frame = make_frame(1'b0, lcd_pkg::init_cmds[cmd_idx]);
			S_ADDR:  frame = make_frame(1'b0, 8'h80 | lcd_pkg::row_base[row]);
			default: frame = make_frame(1'b1, buf_q);
		endcase
	end

	assign frame_valid = (state == S_INIT) || (state == S_ADDR) ||
		(state == S_DATA && buf_full);

	always_comb begin
		ram_req.req   = fetch;
		ram_req.we    = 1'b0;
		ram_req.addr  = fetch_idx;
		ram_req.wdata = 8'h00;
	end

	assign lcd_rst   = (state != S_RST);
	assign busy      = (state == S_ADDR) || (state == S_DATA);
	assign init_done = init_done_q;

endmodule

`default_nettype wire

/* src/txtlcd_top.sv */
/*
 * text lcd controller top
 * apb host port in, 3-wire serial lcd pins out
 */
`timescale 1ns/1ps
`default_nettype none

module txtlcd_top #(
	parameter int MAIN_CLK_HZ   = 27_000_000,
	parameter int SERIAL_CLK_HZ = 1_000_000,
	parameter int LCD_SIZE      = 80,
	parameter int RST_CYCLES    = 27_000
) (
	input  logic              clk27,
	input  logic              arst_n,
	input  bus_pkg::apb_req_t apb_req,
	output bus_pkg::apb_rsp_t apb_rsp,
	output logic              lcd_scl,
	output logic              lcd_sda,
	output logic              lcd_rst
);

	bus_pkg::ram_req_t   host_ram_req;
	bus_pkg::ram_rsp_t   host_ram_rsp;
	bus_pkg::ram_req_t   lcd_ram_req;
	bus_pkg::ram_rsp_t   lcd_ram_rsp;
	bus_pkg::ram_req_t   ram_req;
	logic [7:0]          ram_rdata;
	lcd_pkg::lcd_frame_u frame;
	logic                frame_valid;
	logic                frame_ready;
	logic                update_req;
	logic                busy;
	logic                init_done;

	// ------------------------------------------------------------
	// host side
	// ------------------------------------------------------------
	apb_text_regs #(.LCD_SIZE(LCD_SIZE)) regs_mod (
		.clk27(clk27), .arst_n(arst_n),
		.apb_req(apb_req), .ram_rsp(host_ram_rsp),
		.busy(busy), .init_done(init_done),
		.apb_rsp(apb_rsp), .ram_req(host_ram_req),
		.update_req(update_req)
	);

	// shared text memory
	ram_arbiter arb_mod (
		.clk27(clk27), .arst_n(arst_n),
		.host_req(host_ram_req), .lcd_req(lcd_ram_req), .rdata(ram_rdata),
		.host_rsp(host_ram_rsp), .lcd_rsp(lcd_ram_rsp), .ram_req(ram_req)
	);

	text_ram #(.LCD_SIZE(LCD_SIZE)) ram_mod (
		.clk27(clk27), .req(ram_req), .rdata(ram_rdata)
	);

	// ------------------------------------------------------------
	// display side
	// ------------------------------------------------------------
	txtlcd_refresh #(.LCD_SIZE(LCD_SIZE), .RST_CYCLES(RST_CYCLES)) refresh_mod (
		.clk27(clk27), .arst_n(arst_n),
		.update_req(update_req), .ram_rsp(lcd_ram_rsp), .frame_ready(frame_ready),
		.ram_req(lcd_ram_req), .frame(frame), .frame_valid(frame_valid),
		.lcd_rst(lcd_rst), .busy(busy), .init_done(init_done)
	);

	serial_shifter #(.MAIN_CLK_HZ(MAIN_CLK_HZ), .SERIAL_CLK_HZ(SERIAL_CLK_HZ)) serial_mod (
		.clk27(clk27), .arst_n(arst_n),
		.frame(frame), .frame_valid(frame_valid), .frame_ready(frame_ready),
		.lcd_scl(lcd_scl), .lcd_sda(lcd_sda)
	);

endmodule

`default_nettype wire

/* verification/txtlcd_tb.sv */
/*
 * text lcd controller testbench
 * apb host driver, serial frame decoder and a table of steps with checks
 */
`timescale 1ns/1ps
`default_nettype none

module txtlcd_tb;

	localparam int MAIN_HZ   = 4_000_000;
	localparam int SER_HZ    = 1_000_000;
	localparam int RST_CYC   = 8;
	localparam int SIZE      = 80;
	localparam int CLK_NS    = 4;
	localparam int DIV       = MAIN_HZ / SER_HZ;
	// 24 data clocks plus one idle clock per frame
	localparam int FRAME_NS  = 25 * DIV * CLK_NS;
	localparam int FRAME_CYC = FRAME_NS / CLK_NS;
	// one address command and 20 characters per row
	localparam int SCREEN_FR = 4 * 21;
	// init, single refresh, contention refresh, double refresh
	localparam int TOTAL_FR  = 4 + 4 * SCREEN_FR;
	localparam longint WDOG_NS = longint'(TOTAL_FR) * FRAME_NS + 60_000;
	localparam int APB_TMO   = 32;

	localparam logic [2:0] OP_WR   = 3'd0;
	localparam logic [2:0] OP_RD   = 3'd1;
	localparam logic [2:0] OP_UPD  = 3'd2;
	localparam logic [2:0] OP_INIT = 3'd3;
	localparam logic [2:0] OP_CHK  = 3'd4;

	localparam logic [5:0] A_CTRL = 6'h00;
	localparam logic [5:0] A_STAT = 6'h01;
	localparam logic [5:0] A_WIN  = 6'h10;

	// hd44780 codes: 4-line function set, display on, clear, entry increment
	localparam logic [7:0] INIT_EXP [4] = '{8'h38, 8'h0c, 8'h01, 8'h06};

	typedef struct packed {
		logic [2:0]  op;
		logic [5:0]  addr;
		logic [31:0] data;
		logic [31:0] exp;
		logic        exp_err;
		logic [2:0]  test;
	} step_t;

	logic              clk27;
	logic              arst_n;
	bus_pkg::apb_req_t apb_req;
	bus_pkg::apb_rsp_t apb_rsp;
	logic              lcd_scl;
	logic              lcd_sda;
	logic              lcd_rst;

	int         seed = 81950;
	int         err_cnt = 0;
	int         chk_cnt = 0;
	int         cur_test = 0;
	int         test_err [7];
	string      test_name [7];
	step_t      steps [$];
	// build-time screen model, live model and copy taken at each update
	logic [7:0] model_scr [SIZE];
	logic [7:0] live_scr [SIZE];
	logic [7:0] snap_scr [SIZE];
	// decoded frames
	logic       rx_rs_q [$];
	logic [7:0] rx_byte_q [$];
	logic [23:0] rx_bits = '0;
	int         rx_cnt = 0;

	txtlcd_top #(
		.MAIN_CLK_HZ(MAIN_HZ), .SERIAL_CLK_HZ(SER_HZ),
		.LCD_SIZE(SIZE), .RST_CYCLES(RST_CYC)
	) dut (
		.clk27(clk27), .arst_n(arst_n),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.lcd_scl(lcd_scl), .lcd_sda(lcd_sda), .lcd_rst(lcd_rst)
	);

	initial begin
		clk27 = 1'b0;
		forever #(CLK_NS / 2) clk27 = ~clk27;
	end

	initial begin
		#(WDOG_NS);
		$display("watchdog: run exceeded %0d ns and was stopped", WDOG_NS);
		$display("TB FAILED");
		$finish;
	end

	task automatic note_error();
		err_cnt++;
		test_err[cur_test]++;
	endtask

	// ------------------------------------------------------------
	// serial decoder, bits arrive low bit first on rising scl
	// ------------------------------------------------------------
	always @(posedge lcd_scl) begin
		if (arst_n === 1'b1) begin
			rx_bits = {lcd_sda, rx_bits[23:1]};
			rx_cnt++;
			if (rx_cnt == 24) begin
				rx_cnt = 0;
				chk_cnt++;
				assert (rx_bits[4:0] == 5'b11111) else begin
					$display("FAILED lcd_sda sync bits: expected 1f, got %h", rx_bits[4:0]);
					note_error();
				end
				// bit 5 is read/write, bit 7 the closing zero
				assert (rx_bits[5] == 1'b0 && rx_bits[7] == 1'b0) else begin
					$display("frame start byte %h is not a plain write", rx_bits[7:0]);
					note_error();
				end
				rx_rs_q.push_back(rx_bits[6]);
				rx_byte_q.push_back({rx_bits[19:16], rx_bits[11:8]});
			end
		end
	end

	// ------------------------------------------------------------
	// apb host
	// ------------------------------------------------------------
	// entered and left 1 ns after a rising edge
	task automatic apb_xfer(input logic wr, input logic [5:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output logic ok);
		int n;
		rdata = '0;
		err   = 1'b0;
		ok    = 1'b0;
		n     = 0;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk27);
		#1;
		apb_req.penable = 1'b1;
		// sample mid-cycle, the transfer ends on the next rising edge
		while (!ok && n < APB_TMO) begin
			@(negedge clk27);
			if (apb_rsp.pready) begin
				ok    = 1'b1;
				rdata = apb_rsp.prdata;
				err   = apb_rsp.pslverr;
			end
			n++;
		end
		@(posedge clk27);
		#1;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic apb_step(input step_t s, input logic wr);
		logic [31:0] rd;
		logic        err;
		logic        ok;
		apb_xfer(wr, s.addr, s.data, rd, err, ok);
		chk_cnt++;
		assert (ok) else begin
			$display("APB access to %h got no pready within %0d cycles", s.addr, APB_TMO);
			note_error();
		end
		if (ok) begin
			assert (err == s.exp_err) else begin
				$display("FAILED pslverr at %h: expected %h, got %h", s.addr, s.exp_err, err);
				note_error();
			end
			if (!wr) begin
				assert (rd == s.exp) else begin
					$display("FAILED prdata at %h: expected %h, got %h", s.addr, s.exp, rd);
					note_error();
				end
			end
		end
	endtask

	task automatic pop_frame(output logic rs, output logic [7:0] b, output logic got);
		got = (rx_byte_q.size() > 0);
		rs  = 1'b0;
		b   = 8'h00;
		if (got) begin
			rs = rx_rs_q.pop_front();
			b  = rx_byte_q.pop_front();
		end
	endtask

	// ------------------------------------------------------------
	// frame checks
	// ------------------------------------------------------------
	task automatic check_init();
		int         n;
		int         i;
		logic       rs;
		logic       got;
		logic [7:0] b;
		chk_cnt++;
		assert (lcd_rst === 1'b0 && lcd_scl === 1'b1) else begin
			$display("lcd_rst is not low or lcd_scl is not high right after reset");
			note_error();
		end
		n = 0;
		while (lcd_rst !== 1'b1 && n < 4 * RST_CYC) begin
			@(posedge clk27);
			#1;
			n++;
		end
		chk_cnt++;
		assert (lcd_rst === 1'b1) else begin
			$display("lcd_rst was never released");
			note_error();
		end
		n = 0;
		while (rx_byte_q.size() < 4 && n < 8 * FRAME_CYC) begin
			@(posedge clk27);
			#1;
			n++;
		end
		// room for a stray fifth frame to show up
		repeat (2 * FRAME_CYC) @(posedge clk27);
		#1;
		chk_cnt++;
		assert (rx_byte_q.size() == 4) else begin
			$display("expected 4 init frames, decoded %0d", rx_byte_q.size());
			note_error();
		end
		for (i = 0; i < 4; i++) begin
			pop_frame(rs, b, got);
			if (got) begin
				chk_cnt++;
				assert (rs == 1'b0 && b == INIT_EXP[i]) else begin
					$display("FAILED lcd_sda init %0d rs/byte: expected 0/%h, got %h/%h",
						i, INIT_EXP[i], rs, b);
					note_error();
				end
			end
		end
		rx_rs_q.delete();
		rx_byte_q.delete();
	endtask

	task automatic check_refresh(input int n_ref);
		longint      t_lim;
		logic        seen_busy;
		logic [31:0] rd;
		logic        err;
		logic        ok;
		int          exp_n;
		int          f;
		int          r;
		int          c;
		int          idx;
		logic        rs;
		logic        got;
		logic [7:0]  b;
		logic [7:0]  cmd;
		exp_n     = n_ref * SCREEN_FR;
		t_lim     = longint'($time) + longint'(exp_n) * FRAME_NS * 2 + 4 * FRAME_NS;
		seen_busy = 1'b0;
		// poll STATUS while the frames come in
		while (rx_byte_q.size() < exp_n && longint'($time) < t_lim) begin
			apb_xfer(1'b0, A_STAT, 32'h0, rd, err, ok);
			if (ok && rd[0])
				seen_busy = 1'b1;
		end
		chk_cnt++;
		assert (rx_byte_q.size() >= exp_n) else begin
			$display("refresh timed out with %0d of %0d frames decoded", rx_byte_q.size(), exp_n);
			note_error();
		end
		chk_cnt++;
		assert (seen_busy) else begin
			$display("STATUS busy was never seen high during the refresh");
			note_error();
		end
		apb_xfer(1'b0, A_STAT, 32'h0, rd, err, ok);
		chk_cnt++;
		assert (ok && rd[0] == 1'b0) else begin
			$display("FAILED STATUS busy after refresh: expected 0, got %h", rd[0]);
			note_error();
		end
		// no further refresh may follow
		repeat (3 * FRAME_CYC) @(posedge clk27);
		#1;
		chk_cnt++;
		assert (rx_byte_q.size() == exp_n) else begin
			$display("expected %0d refresh frames, decoded %0d", exp_n, rx_byte_q.size());
			note_error();
		end
		for (f = 0; f < n_ref; f++) begin
			for (r = 0; r < 4; r++) begin
				cmd = 8'h80 + 8'(r * 32);
				pop_frame(rs, b, got);
				chk_cnt++;
				assert (got && rs == 1'b0 && b == cmd) else begin
					$display("FAILED lcd_sda row %0d address rs/byte: expected 0/%h, got %h/%h",
						r, cmd, rs, b);
					note_error();
				end
				for (c = 0; c < 20; c++) begin
					idx = r * 20 + c;
					pop_frame(rs, b, got);
					chk_cnt++;
					// old or new character while the host writes during a refresh
					assert (got && rs == 1'b1 && (b == snap_scr[idx] || b == live_scr[idx]))
					else begin
						$display("FAILED lcd_sda cell %0d rs/byte: expected 1/%h or 1/%h, got %h/%h",
							idx, snap_scr[idx], live_scr[idx], rs, b);
						note_error();
					end
				end
			end
		end
		rx_rs_q.delete();
		rx_byte_q.delete();
	endtask

	// ------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------
	task automatic add_step(input logic [2:0] op, input logic [5:0] addr,
		input logic [31:0] data, input logic [31:0] exp, input logic exp_err, input int test);
		step_t s;
		s.op      = op;
		s.addr    = addr;
		s.data    = data;
		s.exp     = exp;
		s.exp_err = exp_err;
		s.test    = 3'(test);
		steps.push_back(s);
	endtask

	function automatic logic [31:0] win_word(input int k);
		return {16'h0000, model_scr[2 * k + 1], model_scr[2 * k]};
	endfunction

	task automatic add_win_write(input int test);
		int          k;
		logic [31:0] w;
		for (k = 0; k < SIZE / 2; k++) begin
			w = $random(seed);
			model_scr[2 * k]     = w[7:0];
			model_scr[2 * k + 1] = w[15:8];
			add_step(OP_WR, A_WIN + 6'(k), w, 32'h0, 1'b0, test);
		end
	endtask

	task automatic add_win_readback(input int test);
		int k;
		for (k = 0; k < SIZE / 2; k++)
			add_step(OP_RD, A_WIN + 6'(k), 32'h0, win_word(k), 1'b0, test);
	endtask

	task automatic build_table();
		logic [31:0] w;
		add_step(OP_INIT, A_CTRL, 32'h0, 32'h0, 1'b0, 1);
		// init done, not busy
		add_step(OP_RD, A_STAT, 32'h0, 32'h2, 1'b0, 1);
		add_win_write(2);
		add_win_readback(2);
		w = $random(seed);
		// past the screen, below the window, top of the window range
		add_step(OP_WR, 6'h38, w, 32'h0, 1'b1, 3);
		add_step(OP_RD, 6'h38, 32'h0, 32'h0, 1'b1, 3);
		add_step(OP_WR, 6'h05, w, 32'h0, 1'b1, 3);
		add_step(OP_RD, 6'h05, 32'h0, 32'h0, 1'b1, 3);
		add_step(OP_WR, 6'h3f, w, 32'h0, 1'b1, 3);
		add_step(OP_RD, 6'h3f, 32'h0, 32'h0, 1'b1, 3);
		add_step(OP_RD, 6'h37, 32'h0, win_word(39), 1'b0, 3);
		add_step(OP_RD, A_WIN, 32'h0, win_word(0), 1'b0, 3);
		add_step(OP_RD, A_CTRL, 32'h0, 32'h0, 1'b0, 3);
		add_step(OP_UPD, A_CTRL, 32'h1, 32'h0, 1'b0, 4);
		add_step(OP_CHK, A_CTRL, 32'd1, 32'h0, 1'b0, 4);
		add_step(OP_RD, A_STAT, 32'h0, 32'h2, 1'b0, 4);
		add_step(OP_UPD, A_CTRL, 32'h1, 32'h0, 1'b0, 5);
		add_win_write(5);
		add_step(OP_CHK, A_CTRL, 32'd1, 32'h0, 1'b0, 5);
		add_win_readback(5);
		add_step(OP_UPD, A_CTRL, 32'h1, 32'h0, 1'b0, 6);
		add_step(OP_UPD, A_CTRL, 32'h1, 32'h0, 1'b0, 6);
		add_step(OP_CHK, A_CTRL, 32'd2, 32'h0, 1'b0, 6);
		add_step(OP_RD, A_STAT, 32'h0, 32'h2, 1'b0, 6);
	endtask

	initial begin
		step_t s;
		int    k;
		arst_n  = 1'b0;
		apb_req = '0;
		test_err = '{default: 0};
		test_name[0] = "none";
		test_name[1] = "init sequence";
		test_name[2] = "window write and read";
		test_name[3] = "error response";
		test_name[4] = "screen refresh";
		test_name[5] = "contention";
		test_name[6] = "update while busy";
		build_table();
		repeat (3) @(posedge clk27);
		#1;
		arst_n = 1'b1;
		foreach (steps[i]) begin
			s        = steps[i];
			cur_test = int'(s.test);
			case (s.op)
				OP_WR: begin
					apb_step(s, 1'b1);
					if (!s.exp_err && s.addr >= A_WIN) begin
						k = 2 * int'(s.addr - A_WIN);
						live_scr[k]     = s.data[7:0];
						live_scr[k + 1] = s.data[15:8];
					end
				end
				OP_RD:   apb_step(s, 1'b0);
				OP_UPD: begin
					snap_scr = live_scr;
					apb_step(s, 1'b1);
				end
				OP_INIT: check_init();
				OP_CHK:  check_refresh(int'(s.data));
				default: $display("unknown table operation %0d", s.op);
			endcase
			if (i == steps.size() - 1 || steps[i + 1].test != s.test) begin
				if (test_err[cur_test] == 0)
					$display("test %0d (%s): ok", cur_test, test_name[cur_test]);
				else
					$display("test %0d (%s): %0d errors", cur_test, test_name[cur_test],
						test_err[cur_test]);
			end
		end
		$display("6 tests, %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
